/* include/gbf_settings.svh */
`ifndef GBF_SETTINGS_SVH
`define GBF_SETTINGS_SVH

// ======================================================================
// global buffer geometry
// ======================================================================

// one buffer word as seen on the write port
`define GBF_PORT_WIDTH 32

// single activation
`define GBF_DATA_WIDTH 8

// one flag bit per activation of a block
`define GBF_FLAG_WIDTH 16

// 16 words per buffer
`define GBF_ADDR_WIDTH 4

`endif

/* logic/gbf_stream_pkg.sv */
`default_nettype none

`include "gbf_settings.svh"

package gbf_stream_pkg;

    // output stream items
    typedef logic [`GBF_DATA_WIDTH-1:0] gbf_act_t;
    typedef logic [`GBF_FLAG_WIDTH-1:0] gbf_flg_t;

    // fetch controller states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        READ = 2'd1,
        LOAD = 2'd2
    } fetch_state_e;

endpackage

`default_nettype wire

/* logic/gbf_mem_pkg.sv */
`default_nettype none

`include "gbf_settings.svh"

package gbf_mem_pkg;

    // items packed into one buffer word
    localparam int ACT_PER_WORD = `GBF_PORT_WIDTH / `GBF_DATA_WIDTH;
    localparam int FLG_PER_WORD = `GBF_PORT_WIDTH / `GBF_FLAG_WIDTH;

    typedef logic [`GBF_ADDR_WIDTH-1:0] gbf_addr_t;

    // one extra bit so a full buffer can be told from an empty one
    typedef logic [`GBF_ADDR_WIDTH:0] gbf_count_t;

    // same word, two decodes; element 0 sits in the top bits
    typedef union packed {
        gbf_stream_pkg::gbf_act_t [0:ACT_PER_WORD-1] act;
        gbf_stream_pkg::gbf_flg_t [0:FLG_PER_WORD-1] flg;
    } gbf_word_u;

endpackage

`default_nettype wire

/* logic/gbf_rd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface gbf_rd_if;
    import gbf_mem_pkg::*;

    // read request from fetch
    logic      en_rd;
    gbf_addr_t addr_rd;

    // sram data, one cycle after en_rd
    gbf_word_u dat_rd;

    // at least one word held and no write this cycle
    logic      avail;

    modport ram (input en_rd, input addr_rd, output dat_rd);

    modport fill (input en_rd, output avail);

    modport fetch (output en_rd, output addr_rd, input dat_rd, input avail);

endinterface

`default_nettype wire

/* logic/gbf_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gbf_settings.svh"

module gbf_ram (
    input  wire logic                   clk,
    input  wire logic                   wr_en,
    input  wire gbf_mem_pkg::gbf_addr_t wr_addr,
    input  wire gbf_mem_pkg::gbf_word_u wr_data,
    gbf_rd_if.ram                       rd
);
    import gbf_mem_pkg::*;

    localparam int DEPTH = 2 ** `GBF_ADDR_WIDTH;

    gbf_word_u mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data shows up the cycle after en_rd
    always_ff @(posedge clk) begin
        if (rd.en_rd) begin
            rd.dat_rd <= mem[rd.addr_rd];
        end
    end

endmodule

`default_nettype wire

/* logic/gbf_fill_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gbf_settings.svh"

module gbf_fill_counter (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic wr_en,
    gbf_rd_if.fill    rd,
    output logic      full
);
    import gbf_mem_pkg::*;

    localparam gbf_count_t DEPTH = gbf_count_t'(2 ** `GBF_ADDR_WIDTH);

    gbf_count_t count;

    // ======================================================================
    // occupancy
    // ======================================================================

    // write and read on the same edge leave the count unchanged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, rd.en_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full = (count == DEPTH);

    // write wins, so no read may start while wr_en is up
    assign rd.avail = (count != '0) && !wr_en;

endmodule

`default_nettype wire

/* logic/gbf_fetch_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module gbf_fetch_fsm (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    gbf_rd_if.fetch                     rd,
    input  wire logic                   empty,
    output logic                        load,
    output gbf_mem_pkg::gbf_word_u      word
);
    import gbf_mem_pkg::*;
    import gbf_stream_pkg::*;

    fetch_state_e state;
    fetch_state_e state_nxt;
    gbf_addr_t    addr;

    // ======================================================================
    // state machine
    // ======================================================================

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // only fetch into an empty unpacker
                if (rd.avail && empty) begin
                    state_nxt = READ;
                end
            end
            READ:    state_nxt = LOAD;
            LOAD:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // read pointer follows the write order, wraps on its own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (state == READ) begin
            addr <= addr + 1'b1;
        end
    end

    // ======================================================================
    // outputs
    // ======================================================================

    assign rd.en_rd   = (state == READ);
    assign rd.addr_rd = addr;

    // sram word is valid during LOAD
    assign load = (state == LOAD);
    assign word = rd.dat_rd;

endmodule

`default_nettype wire

/* logic/word_unpacker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gbf_settings.svh"

module word_unpacker #(
    parameter int ITEM_WIDTH = `GBF_DATA_WIDTH
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   load,
    input  wire gbf_mem_pkg::gbf_word_u word,
    output logic                        empty,
    output logic                        valid,
    input  wire logic                   ready,
    output logic [ITEM_WIDTH-1:0]       item
);
    import gbf_mem_pkg::*;

    localparam int NUM_ITEMS = `GBF_PORT_WIDTH / ITEM_WIDTH;
    localparam int IDX_WIDTH = (NUM_ITEMS > 1) ? $clog2(NUM_ITEMS) : 1;

    gbf_word_u            word_q;
    logic [IDX_WIDTH-1:0] idx;
    logic                 busy;
    logic                 last;

    assign last = (idx == IDX_WIDTH'(NUM_ITEMS - 1));

    // busy from the load until the last item is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (load) begin
            busy <= 1'b1;
            idx  <= '0;
        end else if (busy && ready) begin
            if (last) begin
                busy <= 1'b0;
                idx  <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            word_q <= word;
        end
    end

    assign valid = busy;
    assign empty = !busy;

    // pick the view of the word that matches the item size, left-first
    if (ITEM_WIDTH == `GBF_FLAG_WIDTH) begin : g_flg_view
        assign item = word_q.flg[idx];
    end else begin : g_act_view
        assign item = word_q.act[idx];
    end

endmodule

`default_nettype wire

/* logic/act_gbf_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gbf_settings.svh"

module act_gbf_top (
    input  wire logic                      clk,
    input  wire logic                      rst_n,

    // activation buffer write side
    input  wire logic                      act_wr_en,
    input  wire gbf_mem_pkg::gbf_addr_t    act_wr_addr,
    input  wire gbf_mem_pkg::gbf_word_u    act_wr_data,
    output logic                           act_full,

    // flag buffer write side
    input  wire logic                      flg_wr_en,
    input  wire gbf_mem_pkg::gbf_addr_t    flg_wr_addr,
    input  wire gbf_mem_pkg::gbf_word_u    flg_wr_data,
    output logic                           flg_full,

    // item streams
    output logic                           act_valid,
    input  wire logic                      act_ready,
    output gbf_stream_pkg::gbf_act_t       act_data,
    output logic                           flg_valid,
    input  wire logic                      flg_ready,
    output gbf_stream_pkg::gbf_flg_t       flg_data
);
    import gbf_mem_pkg::*;

    logic      act_load;
    logic      act_empty;
    gbf_word_u act_word;
    logic      flg_load;
    logic      flg_empty;
    gbf_word_u flg_word;

    gbf_rd_if u_act_rd_if ();
    gbf_rd_if u_flg_rd_if ();

    // ======================================================================
    // activation channel
    // ======================================================================

    gbf_ram u_act_ram (
        .clk     (clk),
        .wr_en   (act_wr_en),
        .wr_addr (act_wr_addr),
        .wr_data (act_wr_data),
        .rd      (u_act_rd_if.ram)
    );

    gbf_fill_counter u_act_fill_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (act_wr_en),
        .rd    (u_act_rd_if.fill),
        .full  (act_full)
    );

    gbf_fetch_fsm u_act_fetch_fsm (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (u_act_rd_if.fetch),
        .empty (act_empty),
        .load  (act_load),
        .word  (act_word)
    );

    // four bytes per word
    word_unpacker #(
        .ITEM_WIDTH (`GBF_DATA_WIDTH)
    ) u_act_word_unpacker (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (act_load),
        .word  (act_word),
        .empty (act_empty),
        .valid (act_valid),
        .ready (act_ready),
        .item  (act_data)
    );

    // ======================================================================
    // flag channel
    // ======================================================================

    gbf_ram u_flg_ram (
        .clk     (clk),
        .wr_en   (flg_wr_en),
        .wr_addr (flg_wr_addr),
        .wr_data (flg_wr_data),
        .rd      (u_flg_rd_if.ram)
    );

    gbf_fill_counter u_flg_fill_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (flg_wr_en),
        .rd    (u_flg_rd_if.fill),
        .full  (flg_full)
    );

    gbf_fetch_fsm u_flg_fetch_fsm (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (u_flg_rd_if.fetch),
        .empty (flg_empty),
        .load  (flg_load),
        .word  (flg_word)
    );

    // two flag groups per word
    word_unpacker #(
        .ITEM_WIDTH (`GBF_FLAG_WIDTH)
    ) u_flg_word_unpacker (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (flg_load),
        .word  (flg_word),
        .empty (flg_empty),
        .valid (flg_valid),
        .ready (flg_ready),
        .item  (flg_data)
    );

endmodule

`default_nettype wire

/* tb/tb_act_gbf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gbf_settings.svh"

module tb_act_gbf;
    import gbf_mem_pkg::*;
    import gbf_stream_pkg::*;

    localparam int ACT_ITEMS = `GBF_PORT_WIDTH / `GBF_DATA_WIDTH;
    localparam int FLG_ITEMS = `GBF_PORT_WIDTH / `GBF_FLAG_WIDTH;
    localparam int NUM_ROWS = 16;
    localparam int NUM_PASSES = 4;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * NUM_PASSES * 16 + 600;

    localparam int MODE_RANDOM = 0;
    localparam int MODE_LOW = 1;
    localparam int MODE_HIGH = 2;

    typedef struct packed {
        logic [`GBF_PORT_WIDTH-1:0] act_word;
        logic [`GBF_PORT_WIDTH-1:0] flg_word;
        logic                       act_we;
        logic                       flg_we;
        logic [3:0]                 gap;
    } step_t;

    // act word, flag word, act write, flag write, idle cycles after
    localparam step_t STEPS [NUM_ROWS] = '{
        '{32'h0102_0304, 32'ha5a5_5a5a, 1'b1, 1'b1, 4'd0},
        '{32'h1122_3344, 32'h0f0f_f0f0, 1'b1, 1'b1, 4'd0},
        '{32'hdead_beef, 32'h0000_0000, 1'b1, 1'b0, 4'd3},
        '{32'hcafe_f00d, 32'h1234_5678, 1'b1, 1'b1, 4'd1},
        '{32'h0000_0000, 32'hffff_0001, 1'b0, 1'b1, 4'd0},
        '{32'h8000_0001, 32'h8001_7ffe, 1'b1, 1'b1, 4'd7},
        '{32'h5566_7788, 32'h2468_ace0, 1'b1, 1'b1, 4'd0},
        '{32'h99aa_bbcc, 32'h0000_0000, 1'b1, 1'b0, 4'd2},
        '{32'hffee_ddcc, 32'h1357_9bdf, 1'b1, 1'b1, 4'd0},
        '{32'h0f1e_2d3c, 32'hfedc_ba98, 1'b1, 1'b1, 4'd5},
        '{32'h4b5a_6978, 32'h00ff_ff00, 1'b1, 1'b1, 4'd0},
        '{32'h0000_0000, 32'h7777_8888, 1'b0, 1'b1, 4'd1},
        '{32'h7f80_817e, 32'hc3c3_3c3c, 1'b1, 1'b1, 4'd0},
        '{32'h0123_4567, 32'h0000_0000, 1'b1, 1'b0, 4'd9},
        '{32'h89ab_cdef, 32'h5a5a_a5a5, 1'b1, 1'b1, 4'd0},
        '{32'hfeed_face, 32'h0bad_f00d, 1'b1, 1'b1, 4'd4}
    };

    logic                       clk;
    logic                       rst_n;
    logic                       act_wr_en;
    gbf_addr_t                  act_wr_addr;
    logic [`GBF_PORT_WIDTH-1:0] act_wr_data;
    logic                       act_full;
    logic                       flg_wr_en;
    gbf_addr_t                  flg_wr_addr;
    logic [`GBF_PORT_WIDTH-1:0] flg_wr_data;
    logic                       flg_full;
    logic                       act_valid;
    logic                       act_ready;
    gbf_act_t                   act_data;
    logic                       flg_valid;
    logic                       flg_ready;
    gbf_flg_t                   flg_data;

    logic [31:0] lfsr;
    int          act_mode;
    int          flg_mode;
    int          cycles = 0;
    gbf_addr_t   act_addr;
    gbf_addr_t   flg_addr;
    gbf_act_t    act_exp_q [$];
    gbf_flg_t    flg_exp_q [$];
    logic        act_hold = 1'b0;
    logic        flg_hold = 1'b0;
    gbf_act_t    act_prev;
    gbf_flg_t    flg_prev;

    act_gbf_top u_act_gbf_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .act_wr_en   (act_wr_en),
        .act_wr_addr (act_wr_addr),
        .act_wr_data (act_wr_data),
        .act_full    (act_full),
        .flg_wr_en   (flg_wr_en),
        .flg_wr_addr (flg_wr_addr),
        .flg_wr_data (flg_wr_data),
        .flg_full    (flg_full),
        .act_valid   (act_valid),
        .act_ready   (act_ready),
        .act_data    (act_data),
        .flg_valid   (flg_valid),
        .flg_ready   (flg_ready),
        .flg_data    (flg_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // helpers
    // ======================================================================

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            report_failure("a checked value did not match");
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic pick_ready(input int mode, input logic rnd);
        case (mode)
            MODE_LOW:  return 1'b0;
            MODE_HIGH: return 1'b1;
            default:   return rnd;
        endcase
    endfunction

    task automatic drive_ready();
        logic [31:0] bits;
        random_bits(2, bits);
        act_ready = pick_ready(act_mode, bits[1]);
        flg_ready = pick_ready(flg_mode, bits[0]);
    endtask

    // expected items are queued from the top bits down
    task automatic write_act(input logic [31:0] w);
        act_wr_en = 1'b1;
        act_wr_addr = act_addr;
        act_wr_data = w;
        act_addr = act_addr + 1'b1;
        for (int i = ACT_ITEMS - 1; i >= 0; i--) begin
            act_exp_q.push_back(w[i*`GBF_DATA_WIDTH +: `GBF_DATA_WIDTH]);
        end
    endtask

    task automatic write_flg(input logic [31:0] w);
        flg_wr_en = 1'b1;
        flg_wr_addr = flg_addr;
        flg_wr_data = w;
        flg_addr = flg_addr + 1'b1;
        for (int i = FLG_ITEMS - 1; i >= 0; i--) begin
            flg_exp_q.push_back(w[i*`GBF_FLAG_WIDTH +: `GBF_FLAG_WIDTH]);
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            drive_ready();
            act_wr_en = 1'b0;
            flg_wr_en = 1'b0;
        end
    endtask

    // a row waits while a buffer it writes is full
    task automatic apply_row(input int r, input logic [31:0] key);
        logic blocked;
        blocked = 1'b1;
        while (blocked) begin
            @(negedge clk);
            drive_ready();
            act_wr_en = 1'b0;
            flg_wr_en = 1'b0;
            blocked = (STEPS[r].act_we && act_full) || (STEPS[r].flg_we && flg_full);
            if (!blocked) begin
                if (STEPS[r].act_we) begin
                    write_act(STEPS[r].act_word ^ key);
                end
                if (STEPS[r].flg_we) begin
                    write_flg(STEPS[r].flg_word ^ key);
                end
            end
        end
        idle_cycles(int'(STEPS[r].gap));
    endtask

    task automatic apply_table(input int pass);
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r, 32'(pass) * 32'h0101_0101);
        end
    endtask

    task automatic drain_all();
        act_mode = MODE_HIGH;
        flg_mode = MODE_HIGH;
        while (act_exp_q.size() != 0 || flg_exp_q.size() != 0) begin
            idle_cycles(1);
        end
        idle_cycles(2);
        check_value("act_valid when drained", 32'(act_valid), 32'd0);
        check_value("flg_valid when drained", 32'(flg_valid), 32'd0);
    endtask

    // one word parks in each unpacker, then 16 more fill the sram
    task automatic fill_burst();
        logic [31:0] aw;
        logic [31:0] fw;
        act_mode = MODE_LOW;
        flg_mode = MODE_LOW;
        for (int i = 0; i < 17; i++) begin
            random_bits(32, aw);
            random_bits(32, fw);
            @(negedge clk);
            drive_ready();
            write_act(aw);
            write_flg(fw);
            if (i == 0) begin
                idle_cycles(6);
            end
        end
        idle_cycles(1);
        check_value("act_full after burst", 32'(act_full), 32'd1);
        check_value("flg_full after burst", 32'(flg_full), 32'd1);
        idle_cycles(8);
        check_value("act_full while stalled", 32'(act_full), 32'd1);
        check_value("flg_full while stalled", 32'(flg_full), 32'd1);
        check_value("act_valid while stalled", 32'(act_valid), 32'd1);
        check_value("flg_valid while stalled", 32'(flg_valid), 32'd1);
    endtask

    // ======================================================================
    // scoreboard, hold checks and timeout
    // ======================================================================

    always @(posedge clk) begin
        if (rst_n) begin
            if (act_hold) begin
                check_value("act_valid under back-pressure", 32'(act_valid), 32'd1);
                check_value("act_data under back-pressure", 32'(act_data), 32'(act_prev));
            end
            if (flg_hold) begin
                check_value("flg_valid under back-pressure", 32'(flg_valid), 32'd1);
                check_value("flg_data under back-pressure", 32'(flg_data), 32'(flg_prev));
            end
            if (act_valid && act_ready) begin
                if (act_exp_q.size() == 0) begin
                    report_failure("an activation item came out with none expected");
                end
                check_value("act_data", 32'(act_data), 32'(act_exp_q.pop_front()));
            end
            if (flg_valid && flg_ready) begin
                if (flg_exp_q.size() == 0) begin
                    report_failure("a flag item came out with none expected");
                end
                check_value("flg_data", 32'(flg_data), 32'(flg_exp_q.pop_front()));
            end
            act_hold = act_valid && !act_ready;
            flg_hold = flg_valid && !flg_ready;
            act_prev = act_data;
            flg_prev = flg_data;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            report_failure("timeout: the streams did not finish within the cycle limit");
        end
    end

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin
        rst_n = 1'b0;
        act_wr_en = 1'b0;
        act_wr_addr = '0;
        act_wr_data = '0;
        flg_wr_en = 1'b0;
        flg_wr_addr = '0;
        flg_wr_data = '0;
        act_ready = 1'b0;
        flg_ready = 1'b0;
        lfsr = 32'h4255_cf87;
        act_mode = MODE_RANDOM;
        flg_mode = MODE_RANDOM;
        act_addr = '0;
        flg_addr = '0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("act_valid after reset", 32'(act_valid), 32'd0);
        check_value("flg_valid after reset", 32'(flg_valid), 32'd0);
        check_value("act_full after reset", 32'(act_full), 32'd0);
        check_value("flg_full after reset", 32'(flg_full), 32'd0);

        // random back-pressure on both streams
        apply_table(0);
        drain_all();

        // flags must still drain while activations stall
        act_mode = MODE_LOW;
        flg_mode = MODE_RANDOM;
        apply_table(1);
        while (flg_exp_q.size() != 0) begin
            idle_cycles(1);
        end
        drain_all();

        // fill to full, then the table waits for space across the wrap
        fill_burst();
        act_mode = MODE_RANDOM;
        flg_mode = MODE_RANDOM;
        apply_table(2);
        drain_all();

        act_mode = MODE_HIGH;
        flg_mode = MODE_HIGH;
        apply_table(3);
        drain_all();
        check_value("act_full at end", 32'(act_full), 32'd0);
        check_value("flg_full at end", 32'(flg_full), 32'd0);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
logic/gbf_stream_pkg.sv
logic/gbf_mem_pkg.sv
logic/gbf_rd_if.sv
logic/gbf_ram.sv
logic/gbf_fill_counter.sv
logic/gbf_fetch_fsm.sv
logic/word_unpacker.sv
logic/act_gbf_top.sv
tb/tb_act_gbf.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_act_gbf -f tb.f \
    && ./obj_dir/Vtb_act_gbf > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
